// ==== compile.f ====
hdl/lc_timing_pkg.sv
hdl/lc_state_pkg.sv
hdl/slot_divider.sv
hdl/scan_window_timer.sv
hdl/sync_correlator.sv
hdl/link_state_fsm.sv
hdl/scan_link_ctrl.sv
tests/scan_link_ctrl_assert.sv
tests/scan_link_ctrl_tb.sv

// ==== tests/scan_link_ctrl_tb.sv ====
/*
  testbench for the slave scan and link controller
  p_1us comes every 6 clocks, so one slot is 3750 clocks
  slots are counted here from reset by the 625 tick rule
*/
`timescale 1ns/10ps

module scan_link_ctrl_tb;

  localparam int resp_to_slots = 8;
  localparam int slot_us       = lc_timing_pkg::slot_us;
  localparam int half_slot_us  = lc_timing_pkg::half_slot_us;
  localparam logic [63:0] dac_code  = 64'h4e5a_91c3_2bd7_086f;
  localparam logic [63:0] giac_code = 64'h9e8b_33a1_c2f0_5d76;
  localparam logic [63:0] cac_code  = 64'h3c71_d8a5_6e09_b4c2;
  localparam logic [63:0] idle_sync = 64'h0;

  logic clk_6M, rstz, p_1us;
  logic rx_is_poll, page_scan_en_oneshot, page_scan_cancel_oneshot, inquiry_scan_en;
  logic [lc_timing_pkg::sync_w-1:0] sync_in;
  logic [lc_timing_pkg::sync_w-1:0] syncword_dac, syncword_giac, syncword_cac;
  lc_timing_pkg::corr_cnt_t         corre_threshold;
  lc_timing_pkg::rand_t             is_max_rand;
  lc_timing_pkg::slot_cnt_t         ps_interval, ps_window, is_interval, is_window;
  logic ps, is, spr, conns, tx_packet_st_p;
  lc_state_pkg::link_state_t        state;

  int checks, errors, timeouts;
  int us_ticks, slot_strobes, tx_cnt;   // counted at posedge
  int win_base, win_samples;
  logic win_chk;
  int div_cnt;
  logic rst_seen;
  logic [31:0] lfsr;
  lc_state_pkg::link_state_t last_state;
  lc_state_pkg::link_state_t trail [$];      // states in visit order
  lc_state_pkg::link_state_t exp_trail [$];

  scan_link_ctrl #(
    .num_scans     (lc_state_pkg::num_scans),
    .resp_to_slots (resp_to_slots)
  ) uut (.*);

  always #10 clk_6M = ~clk_6M;   // 20 ns period

  // 1 us tick, every 6th clock
  always @(posedge clk_6M)
  begin
    rst_seen = rstz;
    #2;
    if (!rst_seen)
    begin
      div_cnt = 0;
      p_1us   = 1'b0;
    end
    else
    begin
      p_1us   = (div_cnt == 5);
      div_cnt = (div_cnt == 5) ? 0 : div_cnt + 1;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  function automatic logic window_open(input int k, input int interval, input int window);
    return (k % interval) < window;      // slot k since enable rise
  endfunction

  function automatic int agree_count(input logic [63:0] a, input logic [63:0] b);
    int n;
    n = 0;
    for (int i = 0; i < 64; i++)
      if (a[i] == b[i])
        n++;
    return n;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      val  = (val << 1) | lfsr[0];
    end
  endtask

  // n distinct flipped bits, last one picked is reported
  task automatic make_flips(input int n, output logic [63:0] mask, output int last);
    int pos;
    int got;
    mask = '0;
    got  = 0;
    last = 0;
    for (int k = 0; k < 1024 && got < n; k++)
    begin
      take_bits(6, pos);
      if (!mask[pos])
      begin
        mask[pos] = 1'b1;
        last      = pos;
        got++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////
  task automatic check_logic(input string test, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("error %s: expected %b, actual %b", test, exp, act);
    end
  endtask

  task automatic check_state(input string test, input lc_state_pkg::link_state_t exp,
                             input lc_state_pkg::link_state_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("error %s: expected %s, actual %s (%0d)", test, exp.name(), act.name(), act);
    end
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    checks++;
    if (act != exp)
    begin
      errors++;
      $display("error %s: expected %0d, actual %0d", test, exp, act);
    end
  endtask

  task automatic check_trail(input string test);
    check_count({test, " length"}, exp_trail.size(), trail.size());
    for (int i = 0; i < exp_trail.size() && i < trail.size(); i++)
      check_state(test, exp_trail[i], trail[i]);
  endtask

  // compare process, samples before the edge updates
  always @(posedge clk_6M)
  begin
    if (state != last_state)
      trail.push_back(state);
    last_state = state;
    if (tx_packet_st_p)
      tx_cnt++;
    if (p_1us)
    begin
      us_ticks++;
      if (us_ticks % slot_us == 0)
        slot_strobes++;                  // divider wraps here
      if (win_chk && (us_ticks % slot_us) == half_slot_us)
      begin
        win_samples++;
        check_logic("window timing",
                    window_open(slot_strobes - win_base, is_interval, is_window), is);
      end
    end
  end

  //////////////////////////////////////////////////
  // waits, all bounded
  //////////////////////////////////////////////////
  task automatic next_clk();
    @(posedge clk_6M);
    #2;
  endtask

  task automatic wait_state(input lc_state_pkg::link_state_t target, input int max_ticks,
                            input string test);
    int n;
    n = 0;
    while (state != target && n < max_ticks * 6)
    begin
      next_clk();
      n++;
    end
    if (state != target)
    begin
      timeouts++;
      $display("timeout in %s: state %s was never reached", test, target.name());
    end
  endtask

  task automatic wait_ticks(input int n);
    int t;
    int c;
    t = us_ticks + n;
    c = 0;
    while (us_ticks < t && c < (n + 2) * 6)
    begin
      next_clk();
      c++;
    end
    if (us_ticks < t)
    begin
      timeouts++;
      $display("timeout: the 1 us tick stopped");
    end
  endtask

  task automatic wait_slot_pos(input int pos);
    int c;
    c = 0;
    while ((us_ticks % slot_us) != pos && c < (slot_us + 2) * 6)
    begin
      next_clk();
      c++;
    end
    if ((us_ticks % slot_us) != pos)
    begin
      timeouts++;
      $display("timeout: slot position %0d was never reached", pos);
    end
  endtask

  task automatic wait_trail(input int len, input int max_ticks, input string test);
    int c;
    c = 0;
    while (trail.size() < len && c < max_ticks * 6)
    begin
      next_clk();
      c++;
    end
    if (trail.size() < len)
    begin
      timeouts++;
      $display("timeout in %s: only %0d state changes seen", test, trail.size());
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial
  begin
    logic [63:0] mask;
    int          last_pos;
    int          tx0;
    int          s0;
    int          exp_hit;

    clk_6M                   = 1'b0;
    rstz                     = 1'b0;
    p_1us                    = 1'b0;
    sync_in                  = idle_sync;
    syncword_dac             = dac_code;
    syncword_giac            = giac_code;
    syncword_cac             = cac_code;
    corre_threshold          = 7'd58;
    rx_is_poll               = 1'b0;
    page_scan_en_oneshot     = 1'b0;
    page_scan_cancel_oneshot = 1'b0;
    inquiry_scan_en          = 1'b0;
    is_max_rand              = 10'd100;
    ps_interval              = 16'd16;
    ps_window                = 16'd8;
    is_interval              = 16'd8;
    is_window                = 16'd2;
    checks = 0;
    errors = 0;
    timeouts = 0;
    us_ticks = 0;
    slot_strobes = 0;
    tx_cnt = 0;
    win_chk = 1'b0;
    win_base = 0;
    win_samples = 0;
    div_cnt = 0;
    lfsr = 32'hc7678ae2;
    last_state = lc_state_pkg::standby;

    repeat (16) @(posedge clk_6M);
    #2;
    rstz = 1'b1;
    next_clk();

    // inquiry window follows interval 8, window 2
    wait_slot_pos(100);
    inquiry_scan_en = 1'b1;
    win_base        = slot_strobes;
    win_chk         = 1'b1;
    wait_ticks(17 * slot_us);
    win_chk = 1'b0;
    check_count("window samples", 17, win_samples);
    inquiry_scan_en = 1'b0;
    wait_state(lc_state_pkg::standby, 10, "window timing");

    // threshold, just below then reached
    is_interval     = 16'd16;
    is_window       = 16'd12;
    inquiry_scan_en = 1'b1;
    wait_state(lc_state_pkg::inq_scan, 20, "threshold");
    make_flips(64 - corre_threshold + 1, mask, last_pos);
    sync_in = giac_code ^ mask;
    exp_hit = (agree_count(sync_in, giac_code) >= corre_threshold);
    tx0     = tx_cnt;
    wait_ticks(slot_us + 50);
    check_count("threshold below tx", exp_hit, tx_cnt - tx0);
    check_state("threshold below state", lc_state_pkg::inq_scan, state);
    mask[last_pos] = 1'b0;               // one flip fewer
    trail.delete();
    tx0     = tx_cnt;
    sync_in = giac_code ^ mask;
    exp_hit = (agree_count(sync_in, giac_code) >= corre_threshold);
    wait_state(lc_state_pkg::inq_tx_fhs, slot_us + 20, "threshold");
    check_count("threshold reached tx", exp_hit, tx_cnt - tx0);
    check_state("threshold reached state",
                exp_hit ? lc_state_pkg::inq_tx_fhs : lc_state_pkg::inq_scan, state);

    // backoff, visit order only
    inquiry_scan_en = 1'b0;
    sync_in         = idle_sync;
    wait_trail(3, slot_us + 1100, "inquiry backoff");
    exp_trail.delete();
    exp_trail.push_back(lc_state_pkg::inq_tx_fhs);
    exp_trail.push_back(lc_state_pkg::inq_rand);
    exp_trail.push_back(lc_state_pkg::standby);
    check_trail("inquiry backoff");

    // response timeout, no FHS after the ID
    page_scan_en_oneshot = 1'b1;
    next_clk();
    page_scan_en_oneshot = 1'b0;
    wait_state(lc_state_pkg::page_scan, 20, "response timeout");
    sync_in = dac_code;
    wait_state(lc_state_pkg::spr_txid, slot_us + 20, "response timeout");
    sync_in = idle_sync;
    wait_state(lc_state_pkg::spr_rxfhs, half_slot_us + 20, "response timeout");
    s0 = slot_strobes;
    wait_state(lc_state_pkg::standby, (resp_to_slots + 2) * slot_us, "response timeout");
    check_logic("response timeout slots", 1'b1, (slot_strobes - s0) <= resp_to_slots + 1);
    check_logic("response timeout spr", 1'b0, spr);

    // cancel during page scan
    wait_state(lc_state_pkg::page_scan, 17 * slot_us, "cancel");
    check_logic("cancel ps before", 1'b1, ps);
    page_scan_cancel_oneshot = 1'b1;
    next_clk();
    page_scan_cancel_oneshot = 1'b0;
    wait_state(lc_state_pkg::standby, 10, "cancel");
    check_logic("cancel ps", 1'b0, ps);
    check_state("cancel state", lc_state_pkg::standby, state);

    // full page response into conn_active, terminal
    page_scan_en_oneshot = 1'b1;
    next_clk();
    page_scan_en_oneshot = 1'b0;
    wait_state(lc_state_pkg::page_scan, 20, "page response");
    trail.delete();
    tx0     = tx_cnt;
    sync_in = dac_code;
    wait_state(lc_state_pkg::spr_ackfhs, 3 * slot_us, "page response");
    sync_in    = cac_code;               // master poll on the CAC
    rx_is_poll = 1'b1;
    wait_state(lc_state_pkg::conn_active, 3 * slot_us, "page response");
    check_logic("page response conns", 1'b1, conns);
    check_count("page response tx pulses", 2, tx_cnt - tx0);
    exp_trail.delete();
    exp_trail.push_back(lc_state_pkg::page_scan);   // logged a clock after entry
    exp_trail.push_back(lc_state_pkg::spr_txid);
    exp_trail.push_back(lc_state_pkg::spr_rxfhs);
    exp_trail.push_back(lc_state_pkg::spr_rxfhs_done);
    exp_trail.push_back(lc_state_pkg::spr_ackfhs);
    exp_trail.push_back(lc_state_pkg::conn_new_slave);
    exp_trail.push_back(lc_state_pkg::conn_active);
    wait_trail(exp_trail.size(), 2, "page response");
    check_trail("page response");

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== tests/scan_link_ctrl_assert.sv ====
/*
  concurrent checks on the link state FSM, bound into every instance
  reset check assumes rstz is released synchronously to clk_6M
*/
`timescale 1ns/10ps

module scan_link_ctrl_assert (
  input logic                      clk_6M,
  input logic                      rstz,
  input logic                      tx_packet_st_p,
  input logic                      ps,
  input logic                      is,
  input logic                      spr,
  input logic                      conns,
  input lc_state_pkg::link_state_t state
);

  //////////////////////////////////////////////////
  // FSM output rules
  //////////////////////////////////////////////////
  tx_one_clock: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_packet_st_p |=> !tx_packet_st_p)
    else $error("tx_packet_st_p longer than one clock");

  // at most one state flag
  flags_exclusive: assert property (@(posedge clk_6M) disable iff (!rstz)
    $onehot0({ps, is, spr, conns}))
    else $error("ps, is, spr, conns overlap");

  standby_in_reset: assert property (@(posedge clk_6M)
    !rstz |-> state == lc_state_pkg::standby)
    else $error("state not standby during reset");

endmodule

bind link_state_fsm scan_link_ctrl_assert u_fsm_assert (
  .clk_6M         (clk_6M),
  .rstz           (rstz),
  .tx_packet_st_p (tx_packet_st_p),
  .ps             (ps),
  .is             (is),
  .spr            (spr),
  .conns          (conns),
  .state          (state)
);

// ==== hdl/scan_link_ctrl.sv ====
/*
  slave link controller top, page scan and inquiry scan side
  sync_in is sampled on p_1us, all strobes are one clk_6M wide
*/
`timescale 1ns/10ps

module scan_link_ctrl #(
  parameter int num_scans     = lc_state_pkg::num_scans,
  parameter int resp_to_slots = 8
) (
  input  logic                              clk_6M,
  input  logic                              rstz,
  input  logic                              p_1us,
  input  logic [lc_timing_pkg::sync_w-1:0]  sync_in,
  input  lc_timing_pkg::corr_cnt_t          corre_threshold,
  input  logic                              rx_is_poll,
  input  logic                              page_scan_en_oneshot,
  input  logic                              page_scan_cancel_oneshot,
  input  logic                              inquiry_scan_en,
  input  logic [lc_timing_pkg::sync_w-1:0]  syncword_dac,
  input  logic [lc_timing_pkg::sync_w-1:0]  syncword_giac,
  input  logic [lc_timing_pkg::sync_w-1:0]  syncword_cac,
  input  lc_timing_pkg::rand_t              is_max_rand,
  input  lc_timing_pkg::slot_cnt_t          ps_interval,
  input  lc_timing_pkg::slot_cnt_t          ps_window,
  input  lc_timing_pkg::slot_cnt_t          is_interval,
  input  lc_timing_pkg::slot_cnt_t          is_window,
  output logic                              ps,
  output logic                              is,
  output logic                              spr,
  output logic                              conns,
  output logic                              tx_packet_st_p,
  output lc_state_pkg::link_state_t         state
);

  logic                             tslot_p, half_tslot_p;
  logic                             match, slot_dly_p, half_dly_p;
  logic                             corr_window;
  logic [lc_timing_pkg::sync_w-1:0] ref_sync;
  logic [num_scans-1:0]             scan_enables, scan_windows;
  lc_timing_pkg::slot_cnt_t         intervals [num_scans];
  lc_timing_pkg::slot_cnt_t         windows [num_scans];

  // scan register pairs by index
  assign intervals[lc_state_pkg::scan_page] = ps_interval;
  assign windows[lc_state_pkg::scan_page]   = ps_window;
  assign intervals[lc_state_pkg::scan_inq]  = is_interval;
  assign windows[lc_state_pkg::scan_inq]    = is_window;

  slot_divider u_slot_div (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .p_1us        (p_1us),
    .tslot_p      (tslot_p),
    .half_tslot_p (half_tslot_p)
  );

  for (genvar i = 0; i < num_scans; i++)
  begin : g_scan
    scan_window_timer u_timer (
      .clk_6M      (clk_6M),
      .rstz        (rstz),
      .tslot_p     (tslot_p),
      .enable      (scan_enables[i]),
      .interval    (intervals[i]),
      .window      (windows[i]),
      .scan_window (scan_windows[i])
    );
  end

  sync_correlator u_corr (
    .clk_6M          (clk_6M),
    .rstz            (rstz),
    .p_1us           (p_1us),
    .corr_window     (corr_window),
    .sync_in         (sync_in),
    .ref_sync        (ref_sync),
    .corre_threshold (corre_threshold),
    .match           (match),
    .slot_dly_p      (slot_dly_p),
    .half_dly_p      (half_dly_p)
  );

  link_state_fsm #(.resp_to_slots(resp_to_slots)) u_fsm (
    .clk_6M                   (clk_6M),
    .rstz                     (rstz),
    .p_1us                    (p_1us),
    .tslot_p                  (tslot_p),
    .half_tslot_p             (half_tslot_p),
    .match                    (match),
    .slot_dly_p               (slot_dly_p),
    .half_dly_p               (half_dly_p),
    .rx_is_poll               (rx_is_poll),
    .page_scan_en_oneshot     (page_scan_en_oneshot),
    .page_scan_cancel_oneshot (page_scan_cancel_oneshot),
    .inquiry_scan_en          (inquiry_scan_en),
    .scan_windows             (scan_windows),
    .syncword_dac             (syncword_dac),
    .syncword_giac            (syncword_giac),
    .syncword_cac             (syncword_cac),
    .is_max_rand              (is_max_rand),
    .scan_enables             (scan_enables),
    .corr_window              (corr_window),
    .ps                       (ps),
    .is                       (is),
    .spr                      (spr),
    .conns                    (conns),
    .tx_packet_st_p           (tx_packet_st_p),
    .ref_sync                 (ref_sync),
    .state                    (state)
  );

endmodule

// ==== hdl/link_state_fsm.sv ====
/*
  slave link state machine, scans, page response, inquiry response
  state moves only on p_1us, strobes all ride on p_1us
  in connection states the correlator listens in the first half slot
*/
`timescale 1ns/10ps

module link_state_fsm #(
  parameter int resp_to_slots = 8
) (
  input  logic                                  clk_6M,
  input  logic                                  rstz,
  input  logic                                  p_1us,
  input  logic                                  tslot_p,
  input  logic                                  half_tslot_p,
  input  logic                                  match,
  input  logic                                  slot_dly_p,
  input  logic                                  half_dly_p,
  input  logic                                  rx_is_poll,
  input  logic                                  page_scan_en_oneshot,
  input  logic                                  page_scan_cancel_oneshot,
  input  logic                                  inquiry_scan_en,
  input  logic [lc_state_pkg::num_scans-1:0]    scan_windows,
  input  logic [lc_timing_pkg::sync_w-1:0]      syncword_dac,
  input  logic [lc_timing_pkg::sync_w-1:0]      syncword_giac,
  input  logic [lc_timing_pkg::sync_w-1:0]      syncword_cac,
  input  lc_timing_pkg::rand_t                  is_max_rand,
  output logic [lc_state_pkg::num_scans-1:0]    scan_enables,
  output logic                                  corr_window,
  output logic                                  ps,
  output logic                                  is,
  output logic                                  spr,
  output logic                                  conns,
  output logic                                  tx_packet_st_p,
  output logic [lc_timing_pkg::sync_w-1:0]      ref_sync,
  output lc_state_pkg::link_state_t             state
);

  localparam int uw = lc_timing_pkg::us_cnt_w;

  lc_state_pkg::link_state_t cs, ns;
  logic                      page_win, inq_win;
  logic                      page_scan_en;
  logic                      got_match;   // match seen in this state
  logic                      seen;
  logic                      rx_half;     // master to slave half slot
  logic [uw-1:0]             us_cnt;      // ticks since state entry
  lc_timing_pkg::slot_cnt_t  resp_cnt;
  logic                      resp_to, fhs_done, rand_done;

  assign page_win  = scan_windows[lc_state_pkg::scan_page];
  assign inq_win   = scan_windows[lc_state_pkg::scan_inq];
  assign seen      = got_match | match;
  assign resp_to   = tslot_p &
                     (resp_cnt == lc_timing_pkg::slot_cnt_t'(resp_to_slots - 1));
  assign fhs_done  = p_1us & (us_cnt == uw'(lc_timing_pkg::slot_us - 1));
  assign rand_done = p_1us & (us_cnt == uw'(is_max_rand));  // max_rand+1 ticks

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////
  always_comb
  begin
    ns = cs;
    case (cs)
      lc_state_pkg::standby:
        if (inq_win)
          ns = lc_state_pkg::inq_scan;   // inquiry scan first
        else if (page_win)
          ns = lc_state_pkg::page_scan;
      lc_state_pkg::page_scan:
        if (!page_win)
          ns = lc_state_pkg::standby;
        else if (seen & slot_dly_p)
          ns = lc_state_pkg::spr_txid;
      lc_state_pkg::spr_txid:
        if (half_dly_p)
          ns = lc_state_pkg::spr_rxfhs;
      lc_state_pkg::spr_rxfhs:
        if (match)
          ns = lc_state_pkg::spr_rxfhs_done;
        else if (resp_to)
          ns = lc_state_pkg::standby;    // no FHS from master
      lc_state_pkg::spr_rxfhs_done:
        if (tslot_p)
          ns = lc_state_pkg::spr_ackfhs;
      lc_state_pkg::spr_ackfhs:
        if (tslot_p)
          ns = lc_state_pkg::conn_new_slave;
      lc_state_pkg::conn_new_slave:
        if (seen & rx_is_poll & tslot_p)
          ns = lc_state_pkg::conn_active; // poll from master
      lc_state_pkg::conn_active:
        ns = cs;
      lc_state_pkg::inq_scan:
        if (!inq_win)
          ns = lc_state_pkg::standby;
        else if (seen & slot_dly_p)
          ns = lc_state_pkg::inq_tx_fhs;
      lc_state_pkg::inq_tx_fhs:
        if (fhs_done)
          ns = lc_state_pkg::inq_rand;
      lc_state_pkg::inq_rand:
        if (rand_done)
          ns = lc_state_pkg::standby;
      default:
        ns = lc_state_pkg::standby;
    endcase
  end

  //////////////////////////////////////////////////
  // state and per state counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      cs        <= lc_state_pkg::standby;
      got_match <= 1'b0;
      us_cnt    <= '0;
      resp_cnt  <= '0;
    end
    else if (p_1us)
    begin
      cs        <= ns;
      got_match <= (ns == cs) & seen;             // cleared on any move
      us_cnt    <= (ns != cs) ? '0 : us_cnt + 1'b1;
      if (cs != lc_state_pkg::spr_rxfhs)
        resp_cnt <= '0;
      else if (tslot_p)
        resp_cnt <= resp_cnt + 1'b1;
    end
  end

  // page scan enable and rx half slot
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      page_scan_en <= 1'b0;
      rx_half      <= 1'b0;
    end
    else
    begin
      if (page_scan_en_oneshot)
        page_scan_en <= 1'b1;
      else if (page_scan_cancel_oneshot |
               (p_1us & (cs == lc_state_pkg::spr_ackfhs) & (ns != cs)))
        page_scan_en <= 1'b0;                      // done once connected
      if (tslot_p)
        rx_half <= 1'b1;
      else if (half_tslot_p)
        rx_half <= 1'b0;
    end
  end

  assign scan_enables[lc_state_pkg::scan_page] = page_scan_en;
  assign scan_enables[lc_state_pkg::scan_inq]  = inquiry_scan_en;

  //////////////////////////////////////////////////
  // correlator control
  //////////////////////////////////////////////////
  always_comb
  begin
    case (cs)
      lc_state_pkg::page_scan:      corr_window = page_win;
      lc_state_pkg::inq_scan:       corr_window = inq_win;
      lc_state_pkg::spr_rxfhs:      corr_window = 1'b1;   // FHS any time
      lc_state_pkg::conn_new_slave,
      lc_state_pkg::conn_active:    corr_window = rx_half;
      default:                      corr_window = 1'b0;
    endcase
  end

  always_comb
  begin
    if (ps | spr)
      ref_sync = syncword_dac;
    else if (cs inside {lc_state_pkg::inq_scan, lc_state_pkg::inq_tx_fhs,
                        lc_state_pkg::inq_rand})
      ref_sync = syncword_giac;
    else if (conns)
      ref_sync = syncword_cac;
    else
      ref_sync = '0;
  end

  // state flags
  assign ps    = (cs == lc_state_pkg::page_scan);
  assign is    = (cs == lc_state_pkg::inq_scan);
  assign spr   = cs inside {lc_state_pkg::spr_txid, lc_state_pkg::spr_rxfhs,
                            lc_state_pkg::spr_rxfhs_done, lc_state_pkg::spr_ackfhs};
  assign conns = cs inside {lc_state_pkg::conn_new_slave, lc_state_pkg::conn_active};
  assign state = cs;

  // packet start on entry to a tx state
  assign tx_packet_st_p = p_1us & (ns != cs) &
                          (ns inside {lc_state_pkg::spr_txid, lc_state_pkg::spr_ackfhs,
                                      lc_state_pkg::inq_tx_fhs});

endmodule

// ==== hdl/sync_correlator.sv ====
/*
  sync word correlator against a state chosen access code
  match fires on the first tick of a run of hits, not on every tick
  slot and half slot delays repeat each slot, realigned by every match
*/
`timescale 1ns/10ps

module sync_correlator (
  input  logic                              clk_6M,
  input  logic                              rstz,
  input  logic                              p_1us,
  input  logic                              corr_window,
  input  logic [lc_timing_pkg::sync_w-1:0]  sync_in,
  input  logic [lc_timing_pkg::sync_w-1:0]  ref_sync,
  input  lc_timing_pkg::corr_cnt_t          corre_threshold,
  output logic                              match,
  output logic                              slot_dly_p,
  output logic                              half_dly_p
);

  localparam int uw = lc_timing_pkg::us_cnt_w;

  lc_timing_pkg::corr_cnt_t agree;   // bits equal to ref
  logic                     hit;
  logic                     hit_d;   // hit on previous tick
  logic                     running;
  logic [uw-1:0]            dly_cnt;
  logic                     dly_wrap;

  // count agreeing bits
  always_comb
  begin
    agree = '0;
    for (int i = 0; i < lc_timing_pkg::sync_w; i++)
      agree = agree + lc_timing_pkg::corr_cnt_t'(~(sync_in[i] ^ ref_sync[i]));
  end

  assign hit   = corr_window & (agree >= corre_threshold);
  assign match = p_1us & hit & ~hit_d;  // leading edge only

  //////////////////////////////////////////////////
  // delay from match
  //////////////////////////////////////////////////
  assign dly_wrap = (dly_cnt == uw'(lc_timing_pkg::slot_us - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      hit_d   <= 1'b0;
      running <= 1'b0;
      dly_cnt <= '0;
    end
    else if (p_1us)
    begin
      hit_d <= hit;
      if (match)
      begin
        running <= 1'b1;
        dly_cnt <= '0;         // realign to latest match
      end
      else if (running)
        dly_cnt <= dly_wrap ? '0 : dly_cnt + 1'b1;
    end
  end

  // 625th and 312th tick after match, then every slot
  assign slot_dly_p = p_1us & running & dly_wrap;
  assign half_dly_p = p_1us & running &
                      (dly_cnt == uw'(lc_timing_pkg::half_slot_us - 1));

endmodule

// ==== hdl/scan_window_timer.sv ====
/*
  periodic scan window, counted in slots
  window opens at once on the rising edge of enable when window > 0
  interval of 0 behaves as the largest interval
*/
`timescale 1ns/10ps

module scan_window_timer (
  input  logic                    clk_6M,
  input  logic                    rstz,
  input  logic                    tslot_p,
  input  logic                    enable,
  input  lc_timing_pkg::slot_cnt_t interval,
  input  lc_timing_pkg::slot_cnt_t window,
  output logic                    scan_window
);

  lc_timing_pkg::slot_cnt_t slot_cnt;
  lc_timing_pkg::slot_cnt_t nxt_cnt;
  logic                     enable_d;
  logic                     enable_rise;

  assign enable_rise = enable & ~enable_d;

  // next slot position, wraps at interval
  always_comb
  begin
    if (slot_cnt >= interval - 1'b1)
      nxt_cnt = '0;
    else
      nxt_cnt = slot_cnt + 1'b1;
  end

  //////////////////////////////////////////////////
  // slot count and window
  //////////////////////////////////////////////////
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      enable_d    <= 1'b0;
      slot_cnt    <= '0;
      scan_window <= 1'b0;
    end
    else
    begin
      enable_d <= enable;
      if (!enable)
      begin
        slot_cnt    <= '0;
        scan_window <= 1'b0;   // closed while disabled
      end
      else if (enable_rise)
      begin
        slot_cnt    <= '0;     // restart period
        scan_window <= (window != '0);
      end
      else if (tslot_p)
      begin
        slot_cnt    <= nxt_cnt;
        scan_window <= (nxt_cnt < window);
      end
    end
  end

endmodule

// ==== hdl/slot_divider.sv ====
/*
  slot strobes from the 1 us tick
  first tslot_p comes on the 625th p_1us after reset
  strobes are combinational, one clk_6M wide
*/
`timescale 1ns/10ps

module slot_divider (
  input  logic clk_6M,
  input  logic rstz,
  input  logic p_1us,
  output logic tslot_p,
  output logic half_tslot_p
);

  localparam int uw = lc_timing_pkg::us_cnt_w;

  logic [uw-1:0] us_cnt;  // 0..624 within a slot
  logic          slot_end;

  assign slot_end = (us_cnt == uw'(lc_timing_pkg::slot_us - 1));

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      us_cnt <= '0;
    else if (p_1us)
    begin
      if (slot_end)
        us_cnt <= '0;        // wrap at slot boundary
      else
        us_cnt <= us_cnt + 1'b1;
    end
  end

  // strobes ride on the tick itself
  assign tslot_p      = p_1us & slot_end;
  assign half_tslot_p = p_1us & (us_cnt == uw'(lc_timing_pkg::half_slot_us));

endmodule

// ==== hdl/lc_state_pkg.sv ====
/*
  link state encoding, slave side only
  conn_active is terminal, only reset leaves it
*/
package lc_state_pkg;

  //////////////////////////////////////////////////
  // link states
  //////////////////////////////////////////////////
  typedef enum logic [3:0] {
    standby        = 4'd0,
    page_scan      = 4'd1,
    spr_txid       = 4'd2,   // slave response, send ID
    spr_rxfhs      = 4'd3,   // wait for master FHS
    spr_rxfhs_done = 4'd4,
    spr_ackfhs     = 4'd5,   // ack FHS with ID
    inq_scan       = 4'd6,
    inq_tx_fhs     = 4'd7,
    inq_rand       = 4'd8,   // random backoff
    conn_new_slave = 4'd9,
    conn_active    = 4'd10
  } link_state_t;

  //////////////////////////////////////////////////
  // scan window indices
  //////////////////////////////////////////////////
  localparam int scan_page = 0;
  localparam int scan_inq  = 1;
  localparam int num_scans = 2;

endpackage

// ==== hdl/lc_timing_pkg.sv ====
/*
  slot timing constants for the slave link controller
  assumes p_1us is a one clock strobe every microsecond of clk_6M
  slot is 625 us, half slot rounded down to 312 us
*/
package lc_timing_pkg;

  //////////////////////////////////////////////////
  // microsecond timing
  //////////////////////////////////////////////////
  localparam int slot_us      = 625;  // us ticks per slot
  localparam int half_slot_us = 312;  // half slot, truncated
  localparam int us_cnt_w     = 11;   // wide enough for two slots

  //////////////////////////////////////////////////
  // slot counters
  //////////////////////////////////////////////////
  localparam int slot_cnt_w = 16;     // matches scan interval registers
  typedef logic [slot_cnt_w-1:0] slot_cnt_t;

  //////////////////////////////////////////////////
  // correlator and backoff
  //////////////////////////////////////////////////
  localparam int sync_w = 64;         // access code sync word
  typedef logic [6:0] corr_cnt_t;     // 0..64 agreeing bits
  typedef logic [9:0] rand_t;         // inquiry scan backoff limit

endpackage
